// File: hw/console_settings.svh
`ifndef CONSOLE_SETTINGS_SVH
`define CONSOLE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Data address map
//////////////////////////////////////////////////////////////////////

// Program and data RAM sits below the sprite region
`define SPRITE_BASE      16'h2000
`define TILE_BASE        16'h2400
`define PALETTE_BASE     16'h4400

// Misc registers
`define STATUS_ADDR      16'h4800
`define PRIORITY_ADDR    16'h4801
`define BRIGHTNESS_ADDR  16'h4802
`define SWITCH_LED_ADDR  16'h4803

//////////////////////////////////////////////////////////////////////
// Program memory
//////////////////////////////////////////////////////////////////////

// Words, 13-bit address
`define PROG_DEPTH       8192

`endif

// File: hw/console_pkg.sv
package console_pkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction set and sequencing
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		ADDI = 4'd4,
		SHR  = 4'd5,
		LUI  = 4'd6,
		LLI  = 4'd7,
		LD   = 4'd8,
		ST   = 4'd9,
		BZ   = 4'd10,
		HALT = 4'd11
	} opcode_t;

	// Four cycles per instruction
	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		RESULT  = 2'd3
	} phase_t;

	//////////////////////////////////////////////////////////////////////
	// Structs passed between core blocks
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_t            op;
		logic [2:0]         rd;
		logic [2:0]         rs;
		logic [2:0]         rt;
		logic [15:0]        imm6;   // already sign-extended
		logic [7:0]         imm8;
		logic signed [8:0]  off9;
	} decoded_instr_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        write;
	} bus_req_t;

	typedef struct packed {
		logic        en;
		logic [2:0]  rd;
		logic        from_mem;
		logic [15:0] value;
	} wb_t;

endpackage

// File: hw/program_memory.sv
`timescale 1ns/1ps
`include "console_settings.svh"

module program_memory (
	input  logic        clk,
	input  logic        a_en,
	input  logic        a_we,
	input  logic [12:0] a_addr,
	input  logic [15:0] a_wdata,
	output logic [15:0] a_rdata,
	input  logic [12:0] b_addr,
	output logic [15:0] b_rdata
);

	logic [15:0] mem [`PROG_DEPTH];

	// Port A, data side and host load, read-first
	always_ff @(posedge clk) begin
		if (a_en) begin
			a_rdata <= mem[a_addr];
			if (a_we) begin
				mem[a_addr] <= a_wdata;
			end
		end
	end

	// Port B, instruction fetch
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

// File: hw/memory_controller.sv
`timescale 1ns/1ps
`include "console_settings.svh"

module memory_controller (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  console_pkg::bus_req_t req,
	output logic [15:0]           rdata,
	input  logic                  load_en,
	input  logic [12:0]           load_addr,
	input  logic [15:0]           load_data,
	input  logic                  hbright,
	input  logic                  vbright,
	input  logic [3:0]            switches,
	input  logic [15:0]           sprite_rdata,
	input  logic [15:0]           tile_rdata,
	input  logic [15:0]           palette_rdata,
	output logic                  sprite_enable,
	output logic                  tile_enable,
	output logic                  palette_enable,
	output logic [9:0]            sprite_addr,
	output logic [12:0]           tile_addr,
	output logic [9:0]            palette_addr,
	output logic [15:0]           bus_wdata,
	output logic                  bus_write,
	output logic [6:0]            sprite_priority,
	output logic [7:0]            brightness,
	output logic [7:0]            test_out,
	input  logic [15:0]           pc,
	output logic [15:0]           instruction
);

	logic        in_prog;
	logic        in_sprite;
	logic        in_tile;
	logic        in_palette;
	logic [3:0]  region_q;
	logic [15:0] misc_q;
	logic [15:0] prog_rdata;
	logic [15:0] sprite_off;
	logic [15:0] tile_off;
	logic [15:0] palette_off;

	//////////////////////////////////////////////////////////////////////
	// Region decode
	//////////////////////////////////////////////////////////////////////

	assign in_prog    = req.addr < `SPRITE_BASE;
	assign in_sprite  = !in_prog && (req.addr < `TILE_BASE);
	assign in_tile    = (req.addr >= `TILE_BASE) && (req.addr < `PALETTE_BASE);
	assign in_palette = (req.addr >= `PALETTE_BASE) && (req.addr < `STATUS_ADDR);

	assign sprite_enable  = run && in_sprite;
	assign tile_enable    = run && in_tile;
	assign palette_enable = run && in_palette;

	// Base-relative offsets for the video RAMs
	assign sprite_off   = req.addr - `SPRITE_BASE;
	assign tile_off     = req.addr - `TILE_BASE;
	assign palette_off  = req.addr - `PALETTE_BASE;
	assign sprite_addr  = sprite_off[9:0];
	assign tile_addr    = tile_off[12:0];
	assign palette_addr = palette_off[9:0];

	assign bus_wdata = req.wdata;
	assign bus_write = req.write;

	// Host load owns port A while the core is stopped
	program_memory program_memory_inst (
		.clk     (clk),
		.a_en    (run ? in_prog : load_en),
		.a_we    (run ? (in_prog && req.write) : load_en),
		.a_addr  (run ? req.addr[12:0] : load_addr),
		.a_wdata (run ? req.wdata : load_data),
		.a_rdata (prog_rdata),
		.b_addr  (pc[12:0]),
		.b_rdata (instruction)
	);

	//////////////////////////////////////////////////////////////////////
	// Misc registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			sprite_priority <= 7'd0;
			brightness      <= 8'd0;
			test_out        <= 8'd0;
			region_q        <= 4'd0;
		end else begin
			region_q <= {in_prog, in_sprite, in_tile, in_palette};
			if (run && req.write) begin
				case (req.addr)
					`PRIORITY_ADDR:   sprite_priority <= req.wdata[6:0];
					`BRIGHTNESS_ADDR: brightness <= req.wdata[7:0];
					`SWITCH_LED_ADDR: test_out <= req.wdata[7:0];
					default:          ;
				endcase
			end
		end
	end

	// Read value lines up with the one-cycle RAM latency
	always_ff @(posedge clk) begin
		case (req.addr)
			`STATUS_ADDR:     misc_q <= {6'd0, hbright, vbright, 8'd0};
			`PRIORITY_ADDR:   misc_q <= {9'd0, sprite_priority};
			`BRIGHTNESS_ADDR: misc_q <= {8'd0, brightness};
			`SWITCH_LED_ADDR: misc_q <= {12'd0, switches};
			default:          misc_q <= 16'd0;
		endcase
	end

	always_comb begin
		if (region_q[3]) begin
			rdata = prog_rdata;
		end else if (region_q[2]) begin
			rdata = sprite_rdata;
		end else if (region_q[1]) begin
			rdata = tile_rdata;
		end else if (region_q[0]) begin
			rdata = palette_rdata;
		end else begin
			rdata = misc_q;
		end
	end

	// Video RAMs never see two enables at once
	assert property (@(posedge clk) disable iff (!rst)
		$onehot0({sprite_enable, tile_enable, palette_enable}));

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        run,
	input  logic [15:0]                 instruction,
	input  logic                        branch_taken,
	input  logic [8:0]                  branch_off,
	output console_pkg::phase_t         phase,
	output logic [15:0]                 pc,
	output console_pkg::decoded_instr_t dec,
	output logic                        halted
);

	//////////////////////////////////////////////////////////////////////
	// Phase sequencer and program counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			phase  <= console_pkg::FETCH;
			pc     <= 16'd0;
			halted <= 1'b0;
		end else if (run && !halted) begin
			case (phase)
				console_pkg::FETCH:   phase <= console_pkg::DECODE;
				console_pkg::DECODE:  phase <= console_pkg::EXECUTE;
				console_pkg::EXECUTE: phase <= console_pkg::RESULT;
				console_pkg::RESULT: begin
					phase <= console_pkg::FETCH;
					if (dec.op == console_pkg::HALT) begin
						halted <= 1'b1;
					end else if (branch_taken) begin
						pc <= pc + 16'd1 + {{7{branch_off[8]}}, branch_off};
					end else begin
						pc <= pc + 16'd1;
					end
				end
			endcase
		end
	end

	// Instruction word is valid from the port during DECODE
	always_ff @(posedge clk) begin
		if (phase == console_pkg::DECODE) begin
			dec.op   <= console_pkg::opcode_t'(instruction[15:12]);
			dec.rd   <= instruction[11:9];
			dec.rs   <= instruction[8:6];
			dec.rt   <= instruction[5:3];
			dec.imm6 <= {{10{instruction[5]}}, instruction[5:0]};
			dec.imm8 <= instruction[7:0];
			dec.off9 <= instruction[8:0];
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		$rose(halted) |-> $past(phase == console_pkg::RESULT && dec.op == console_pkg::HALT));

endmodule

// File: hw/instr_execute.sv
`timescale 1ns/1ps

module instr_execute (
	input  logic                        clk,
	input  logic                        rst,
	input  console_pkg::phase_t         phase,
	input  console_pkg::decoded_instr_t dec,
	input  logic [15:0]                 rs_val,
	input  logic [15:0]                 rt_val,
	input  logic [15:0]                 rd_val,
	output console_pkg::bus_req_t       req,
	output console_pkg::wb_t            wb,
	output logic                        branch_taken,
	output logic [8:0]                  branch_off
);

	logic [15:0] alu_value;
	logic        alu_en;
	logic        mem_op;

	assign mem_op     = (dec.op == console_pkg::LD) || (dec.op == console_pkg::ST);
	assign branch_off = dec.off9;

	always_comb begin
		alu_en = 1'b1;
		case (dec.op)
			console_pkg::ADD:  alu_value = rs_val + rt_val;
			console_pkg::SUB:  alu_value = rs_val - rt_val;
			console_pkg::AND:  alu_value = rs_val & rt_val;
			console_pkg::OR:   alu_value = rs_val | rt_val;
			console_pkg::ADDI: alu_value = rs_val + dec.imm6;
			console_pkg::SHR:  alu_value = rs_val >> dec.imm6[3:0];
			console_pkg::LUI:  alu_value = {dec.imm8, 8'd0};
			console_pkg::LLI:  alu_value = {rd_val[15:8], dec.imm8};
			console_pkg::LD:   alu_value = rs_val + dec.imm6;
			default: begin
				alu_value = 16'd0;
				alu_en    = 1'b0;
			end
		endcase
	end

	// Bus request only during EXECUTE, so the write strobe is one cycle
	always_comb begin
		req = '0;
		if (phase == console_pkg::EXECUTE && mem_op) begin
			req.addr = rs_val + dec.imm6;
			if (dec.op == console_pkg::ST) begin
				req.wdata = rd_val;
				req.write = 1'b1;
			end
		end
	end

	// Write-back and branch results are held for RESULT only
	always_ff @(posedge clk) begin
		if (!rst) begin
			wb           <= '0;
			branch_taken <= 1'b0;
		end else if (phase == console_pkg::EXECUTE) begin
			wb.en        <= alu_en;
			wb.rd        <= dec.rd;
			wb.from_mem  <= dec.op == console_pkg::LD;
			wb.value     <= alu_value;
			branch_taken <= (dec.op == console_pkg::BZ) && (rd_val == 16'd0);
		end else begin
			wb.en        <= 1'b0;
			branch_taken <= 1'b0;
		end
	end

endmodule

// File: hw/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
	input  logic                        clk,
	input  logic                        rst,
	input  console_pkg::phase_t         phase,
	input  console_pkg::decoded_instr_t dec,
	input  console_pkg::wb_t            wb,
	input  logic [15:0]                 rdata,
	output logic [15:0]                 rs_val,
	output logic [15:0]                 rt_val,
	output logic [15:0]                 rd_val
);

	logic [15:0] regs [8];
	logic [15:0] write_value;

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	// Combinational reads, stable through EXECUTE and RESULT
	assign rs_val = regs[dec.rs];
	assign rt_val = regs[dec.rt];
	assign rd_val = regs[dec.rd];

	// Load data arrives from the bus mux during RESULT
	assign write_value = wb.from_mem ? rdata : wb.value;

	always_ff @(posedge clk) begin
		if (wb.en) begin
			regs[wb.rd] <= write_value;
		end
	end

	// Execute must only hand over a write in the final phase
	assert property (@(posedge clk) disable iff (!rst)
		wb.en |-> phase == console_pkg::RESULT);

endmodule

// File: hw/console_core_top.sv
`timescale 1ns/1ps

module console_core_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        run,
	input  logic        load_en,
	input  logic [12:0] load_addr,
	input  logic [15:0] load_data,
	input  logic        hbright,
	input  logic        vbright,
	input  logic [3:0]  switches,
	input  logic [15:0] sprite_rdata,
	input  logic [15:0] tile_rdata,
	input  logic [15:0] palette_rdata,
	output logic        sprite_enable,
	output logic        tile_enable,
	output logic        palette_enable,
	output logic [9:0]  sprite_addr,
	output logic [12:0] tile_addr,
	output logic [9:0]  palette_addr,
	output logic [15:0] bus_wdata,
	output logic        bus_write,
	output logic [6:0]  sprite_priority,
	output logic [7:0]  brightness,
	output logic [7:0]  test_out,
	output logic        halted
);

	console_pkg::phase_t         phase;
	console_pkg::decoded_instr_t dec;
	console_pkg::bus_req_t       req;
	console_pkg::wb_t            wb;
	logic [15:0]                 pc;
	logic [15:0]                 instruction;
	logic [15:0]                 rdata;
	logic [15:0]                 rs_val;
	logic [15:0]                 rt_val;
	logic [15:0]                 rd_val;
	logic                        branch_taken;
	logic [8:0]                  branch_off;

	instr_decode instr_decode_inst (
		.clk          (clk),
		.rst          (rst),
		.run          (run),
		.instruction  (instruction),
		.branch_taken (branch_taken),
		.branch_off   (branch_off),
		.phase        (phase),
		.pc           (pc),
		.dec          (dec),
		.halted       (halted)
	);

	instr_execute instr_execute_inst (
		.clk          (clk),
		.rst          (rst),
		.phase        (phase),
		.dec          (dec),
		.rs_val       (rs_val),
		.rt_val       (rt_val),
		.rd_val       (rd_val),
		.req          (req),
		.wb           (wb),
		.branch_taken (branch_taken),
		.branch_off   (branch_off)
	);

	result_writeback result_writeback_inst (
		.clk    (clk),
		.rst    (rst),
		.phase  (phase),
		.dec    (dec),
		.wb     (wb),
		.rdata  (rdata),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.rd_val (rd_val)
	);

	memory_controller memory_controller_inst (
		.clk             (clk),
		.rst             (rst),
		.run             (run),
		.req             (req),
		.rdata           (rdata),
		.load_en         (load_en),
		.load_addr       (load_addr),
		.load_data       (load_data),
		.hbright         (hbright),
		.vbright         (vbright),
		.switches        (switches),
		.sprite_rdata    (sprite_rdata),
		.tile_rdata      (tile_rdata),
		.palette_rdata   (palette_rdata),
		.sprite_enable   (sprite_enable),
		.tile_enable     (tile_enable),
		.palette_enable  (palette_enable),
		.sprite_addr     (sprite_addr),
		.tile_addr       (tile_addr),
		.palette_addr    (palette_addr),
		.bus_wdata       (bus_wdata),
		.bus_write       (bus_write),
		.sprite_priority (sprite_priority),
		.brightness      (brightness),
		.test_out        (test_out),
		.pc              (pc),
		.instruction     (instruction)
	);

endmodule

// File: verification/console_core_tb.sv
`timescale 1ns/1ps
`include "console_settings.svh"

module console_core_tb;

	localparam int MAX_INSTR = 64;
	localparam int TIMEOUT   = 4 * MAX_INSTR + 32;

	logic        clk;
	logic        rst;
	logic        run;
	logic        load_en;
	logic [12:0] load_addr;
	logic [15:0] load_data;
	logic        hbright;
	logic        vbright;
	logic [3:0]  switches;
	logic [15:0] sprite_rdata;
	logic [15:0] tile_rdata;
	logic [15:0] palette_rdata;
	logic        sprite_enable;
	logic        tile_enable;
	logic        palette_enable;
	logic [9:0]  sprite_addr;
	logic [12:0] tile_addr;
	logic [9:0]  palette_addr;
	logic [15:0] bus_wdata;
	logic        bus_write;
	logic [6:0]  sprite_priority;
	logic [7:0]  brightness;
	logic [7:0]  test_out;
	logic        halted;

	logic [15:0] sprite_mem [1024];
	logic [15:0] tile_mem [8192];
	logic [15:0] palette_mem [1024];
	console_pkg::bus_req_t write_log [$];
	logic [15:0] prog [$];
	int errors;
	int checks;

	console_core_top console_core_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Video RAM models, read one cycle after enable
	//////////////////////////////////////////////////////////////////////

	task automatic log_write(logic [15:0] base, logic [15:0] offset, logic [15:0] data);
		console_pkg::bus_req_t entry;
		entry.addr  = base + offset;
		entry.wdata = data;
		entry.write = 1'b1;
		write_log.push_back(entry);
	endtask

	always @(posedge clk) begin
		if (sprite_enable) begin
			sprite_rdata <= sprite_mem[sprite_addr];
			if (bus_write) begin
				sprite_mem[sprite_addr] <= bus_wdata;
				log_write(`SPRITE_BASE, {6'd0, sprite_addr}, bus_wdata);
			end
		end
		if (tile_enable) begin
			tile_rdata <= tile_mem[tile_addr];
			if (bus_write) begin
				tile_mem[tile_addr] <= bus_wdata;
				log_write(`TILE_BASE, {3'd0, tile_addr}, bus_wdata);
			end
		end
		if (palette_enable) begin
			palette_rdata <= palette_mem[palette_addr];
			if (bus_write) begin
				palette_mem[palette_addr] <= bus_wdata;
				log_write(`PALETTE_BASE, {6'd0, palette_addr}, bus_wdata);
			end
		end
		if (int'(sprite_enable) + int'(tile_enable) + int'(palette_enable) > 1) begin
			errors++;
			$display("More than one video RAM enable is high at %0t", $time);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(string what, logic [15:0] got, logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_region_write(int idx, console_pkg::bus_req_t exp);
		checks++;
		if (idx >= write_log.size()) begin
			errors++;
			$display("Video RAM write %0d never happened", idx);
		end else if (write_log[idx] !== exp) begin
			errors++;
			$display("** Error at %0t: video write %0d is %h/%h, expected %h/%h", $time, idx,
				write_log[idx].addr, write_log[idx].wdata, exp.addr, exp.wdata);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding and program runs
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] enc_r(console_pkg::opcode_t op, int rd, int rs, int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'd0};
	endfunction

	function automatic logic [15:0] enc_i(console_pkg::opcode_t op, int rd, int rs, int imm);
		return {op, rd[2:0], rs[2:0], imm[5:0]};
	endfunction

	function automatic logic [15:0] enc_bz(int rd, int off);
		return {console_pkg::BZ, rd[2:0], off[8:0]};
	endfunction

	task automatic load_const(int r, logic [15:0] value);
		prog.push_back({console_pkg::LUI, r[2:0], 1'b0, value[15:8]});
		prog.push_back({console_pkg::LLI, r[2:0], 1'b0, value[7:0]});
	endtask

	task automatic run_program();
		int cycles;
		@(negedge clk);
		rst = 1'b0;
		run = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b1;
		write_log.delete();
		prog.push_back({console_pkg::HALT, 12'd0});
		foreach (prog[i]) begin
			@(negedge clk);
			load_en   = 1'b1;
			load_addr = i[12:0];
			load_data = prog[i];
		end
		@(negedge clk);
		load_en = 1'b0;
		run     = 1'b1;
		cycles  = 0;
		while (!halted) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timeout: core did not halt within %0d cycles", TIMEOUT);
				$display("Simulation failed");
				$finish;
			end
		end
		prog.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_arith();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		a = 16'($urandom);
		b = 16'($urandom);
		r = ((((a + b) & (a - b)) | a) + 16'hfff9) >> 3;
		load_const(1, a);
		load_const(2, b);
		load_const(0, `SWITCH_LED_ADDR);
		prog.push_back(enc_r(console_pkg::ADD, 3, 1, 2));
		prog.push_back(enc_r(console_pkg::SUB, 4, 1, 2));
		prog.push_back(enc_r(console_pkg::AND, 5, 3, 4));
		prog.push_back(enc_r(console_pkg::OR, 6, 5, 1));
		prog.push_back(enc_i(console_pkg::ADDI, 6, 6, -7));
		prog.push_back(enc_i(console_pkg::SHR, 6, 6, 3));
		prog.push_back(enc_i(console_pkg::ST, 6, 0, 0));
		run_program();
		check_byte("arith test_out", test_out, r[7:0]);
	endtask

	task automatic test_control();
		logic [15:0] v;
		logic [15:0] sum;
		v = 16'h01f5;
		sum = ({9'd0, v[6:0]} << 1) + {8'd0, v[7:0]};
		load_const(1, v);
		load_const(0, `BRIGHTNESS_ADDR);
		prog.push_back(enc_i(console_pkg::ST, 1, 0, 0));
		prog.push_back(enc_i(console_pkg::ST, 1, 0, -1));
		prog.push_back(enc_i(console_pkg::LD, 2, 0, -1));
		prog.push_back(enc_i(console_pkg::LD, 3, 0, 0));
		// Priority counted twice so the two readbacks cannot trade places
		prog.push_back(enc_r(console_pkg::ADD, 2, 2, 2));
		prog.push_back(enc_r(console_pkg::ADD, 4, 2, 3));
		prog.push_back(enc_i(console_pkg::ST, 4, 0, 1));
		run_program();
		check_byte("brightness", brightness, v[7:0]);
		check_byte("sprite_priority", {1'b0, sprite_priority}, {1'b0, v[6:0]});
		check_byte("control readback", test_out, sum[7:0]);
	endtask

	task automatic test_inputs();
		logic [7:0] exp;
		@(negedge clk);
		switches = 4'($urandom);
		hbright  = 1'($urandom);
		// Opposite levels so a swapped status bit shows
		vbright  = !hbright;
		exp = {2'd0, hbright, vbright, switches};
		load_const(0, `STATUS_ADDR);
		load_const(5, 16'hffff);
		prog.push_back(enc_i(console_pkg::LD, 1, 0, 0));
		prog.push_back(enc_i(console_pkg::SHR, 1, 1, 8));
		for (int i = 0; i < 4; i++) begin
			prog.push_back(enc_r(console_pkg::ADD, 1, 1, 1));
		end
		prog.push_back(enc_i(console_pkg::LD, 2, 0, 3));
		// 0x4808 is unmapped
		prog.push_back(enc_i(console_pkg::LD, 5, 0, 8));
		prog.push_back(enc_r(console_pkg::OR, 4, 1, 2));
		prog.push_back(enc_r(console_pkg::OR, 6, 4, 5));
		prog.push_back(enc_i(console_pkg::ST, 6, 0, 3));
		run_program();
		check_byte("status and switches", test_out, exp);
	endtask

	task automatic test_video();
		console_pkg::bus_req_t exp;
		logic [15:0] d0;
		logic [15:0] d1;
		logic [15:0] d2;
		logic [15:0] sum;
		logic [15:0] folded;
		d0 = 16'($urandom);
		d1 = 16'($urandom);
		d2 = 16'($urandom);
		sum = sprite_mem[6] + d1 + palette_mem[10'h3fe];
		folded = sum + (sum >> 8);
		load_const(0, `SPRITE_BASE + 16'd5);
		load_const(1, d0);
		load_const(2, `TILE_BASE + 16'h123);
		load_const(3, d1);
		load_const(4, `PALETTE_BASE + 16'h3ff);
		load_const(5, d2);
		prog.push_back(enc_i(console_pkg::ST, 1, 0, 0));
		prog.push_back(enc_i(console_pkg::ST, 3, 2, 0));
		prog.push_back(enc_i(console_pkg::ST, 5, 4, 0));
		prog.push_back(enc_i(console_pkg::LD, 6, 0, 1));
		prog.push_back(enc_i(console_pkg::LD, 7, 2, 0));
		prog.push_back(enc_r(console_pkg::ADD, 6, 6, 7));
		prog.push_back(enc_i(console_pkg::LD, 7, 4, -1));
		prog.push_back(enc_r(console_pkg::ADD, 6, 6, 7));
		// High byte folded down so the whole load data reaches test_out
		prog.push_back(enc_i(console_pkg::SHR, 7, 6, 8));
		prog.push_back(enc_r(console_pkg::ADD, 6, 6, 7));
		load_const(0, `SWITCH_LED_ADDR);
		prog.push_back(enc_i(console_pkg::ST, 6, 0, 0));
		run_program();
		exp = '{addr: `SPRITE_BASE + 16'd5, wdata: d0, write: 1'b1};
		check_region_write(0, exp);
		exp = '{addr: `TILE_BASE + 16'h123, wdata: d1, write: 1'b1};
		check_region_write(1, exp);
		exp = '{addr: `PALETTE_BASE + 16'h3ff, wdata: d2, write: 1'b1};
		check_region_write(2, exp);
		check_word("video write count", 16'(write_log.size()), 16'd3);
		check_byte("video loads", test_out, folded[7:0]);
	endtask

	task automatic test_prog_ram();
		logic [15:0] d;
		logic [15:0] exp;
		d = 16'($urandom);
		exp = d + (d >> 8);
		load_const(0, 16'h1f00);
		load_const(1, d);
		prog.push_back(enc_i(console_pkg::ST, 1, 0, 0));
		prog.push_back(enc_i(console_pkg::LD, 2, 0, 0));
		prog.push_back(enc_i(console_pkg::SHR, 3, 2, 8));
		prog.push_back(enc_r(console_pkg::ADD, 4, 3, 2));
		load_const(0, `SWITCH_LED_ADDR);
		prog.push_back(enc_i(console_pkg::ST, 4, 0, 0));
		run_program();
		check_byte("program RAM data", test_out, exp[7:0]);
	endtask

	task automatic test_branch();
		int n;
		n = 3 + int'($urandom % 6);
		load_const(1, 16'(n));
		load_const(2, 16'd0);
		load_const(3, 16'hffff);
		load_const(4, 16'd0);
		load_const(0, `SWITCH_LED_ADDR);
		// Countdown loop, r4 stays zero for the jump back
		prog.push_back(enc_bz(1, 3));
		prog.push_back(enc_i(console_pkg::ADDI, 2, 2, 1));
		prog.push_back(enc_r(console_pkg::ADD, 1, 1, 3));
		prog.push_back(enc_bz(4, -4));
		prog.push_back(enc_i(console_pkg::ST, 2, 0, 0));
		run_program();
		check_byte("loop count", test_out, 8'(n));
		repeat (8) @(negedge clk);
		check_byte("halted flag", {7'd0, halted}, 8'd1);
		check_byte("test_out after halt", test_out, 8'(n));
	endtask

	initial begin
		void'($urandom(32'h077c_634e));
		errors    = 0;
		checks    = 0;
		rst       = 1'b0;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		hbright   = 1'b0;
		vbright   = 1'b0;
		switches  = '0;
		sprite_rdata  = '0;
		tile_rdata    = '0;
		palette_rdata = '0;
		for (int i = 0; i < 8192; i++) begin
			tile_mem[i] = 16'(i) ^ 16'h3c5a;
		end
		for (int i = 0; i < 1024; i++) begin
			sprite_mem[i]  = 16'(i) ^ 16'hc3a5;
			palette_mem[i] = 16'(i * 7) ^ 16'h0f0f;
		end
		repeat (2) @(negedge clk);
		rst = 1'b1;
		test_arith();
		test_control();
		test_inputs();
		test_video();
		test_prog_ram();
		test_branch();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+hw
hw/console_pkg.sv
hw/program_memory.sv
hw/memory_controller.sv
hw/instr_decode.sv
hw/instr_execute.sv
hw/result_writeback.sv
hw/console_core_top.sv
verification/console_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= console_core_tb
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
